// ==== bench/mmu_mem_model.sv ====
module mmu_mem_model import mmu_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        req_en,
   input  mem_req_t    req,
   output logic        resp_en,
   output logic [31:0] resp_data
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] SEED = 32'he7e8_5ac4;

   // sparse word store, written by the testbench and by write requests
   logic [31:0] mem [logic [31:0]];

   logic [31:0] seed;
   mem_req_t    cur;
   logic        busy;
   logic [1:0]  cnt;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // unwritten words read back as a pattern of their own address
   function automatic logic [31:0] fill_word(input logic [31:0] a);
      return {a[15:0], a[31:16]} ^ 32'h3c5a_a5c3;
   endfunction

   function automatic logic [31:0] read_word(input logic [31:0] a);
      logic [31:0] w;
      w = {a[31:2], 2'b00};
      return mem.exists(w) ? mem[w] : fill_word(w);
   endfunction

   function automatic logic [31:0] merge_word(input logic [31:0] old, input mem_req_t r);
      logic [31:0] v;
      v = old;
      for (int b = 0; b < 4; b++) begin
         if (r.wstrb[b]) begin
            v[b*8 +: 8] = r.wdata[b*8 +: 8];
         end
      end
      return v;
   endfunction

   always @(posedge clk) begin
      if (rstn) begin
         busy <= 1'b0;
         resp_en <= 1'b0;
         resp_data <= '0;
         cnt <= '0;
         seed <= SEED;
      end else begin
         resp_en <= 1'b0;
         if (req_en) begin
            // latency of 1 to 4 cycles
            busy <= 1'b1;
            cur <= req;
            cnt <= seed[31:30];
            seed <= lcg_next(seed);
         end else if (busy) begin
            if (cnt == 2'd0) begin
               busy <= 1'b0;
               resp_en <= 1'b1;
               if (cur.mode == MEM_WRITE) begin
                  mem[{cur.addr[31:2], 2'b00}] = merge_word(read_word(cur.addr), cur);
                  resp_data <= '0;
               end else begin
                  resp_data <= read_word(cur.addr);
               end
            end else begin
               cnt <= cnt - 2'd1;
            end
         end
      end
   end

endmodule

// ==== bench/tb_mmu.sv ====
module tb_mmu import mmu_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          TIMEOUT_CYCLES = 2000;
   localparam logic [21:0] ROOT_PPN = 22'h100;
   localparam satp_t       SATP_ON = 32'h8000_0100;

   logic        clk;
   logic        rstn;
   satp_t       satp;
   priv_t       cpu_mode;
   logic        sum;
   logic        flush_tlb;
   logic        fetch_req_en;
   mem_req_t    fetch_req;
   logic        fetch_resp_en;
   logic [31:0] fetch_resp_data;
   logic        mem_req_en;
   mem_req_t    mem_req;
   logic        mem_resp_en;
   logic [31:0] mem_resp_data;
   logic        exc_en;
   exc_code_t   exc_code;
   vaddr_t      exc_tval;
   logic        req_en;
   mem_req_t    req;
   logic        resp_en;
   logic [31:0] resp_data;

   // reference copy of the page tables
   pte_t        pt [vaddr_t];
   mem_req_t    reqs [$];
   int          cycles;

   logic [31:0] rdata;
   logic        exc_seen;
   exc_code_t   exc_c;
   vaddr_t      exc_t;

   mmu_top #(
      .TLB_ENTRIES(16)
   ) i_dut (
      .clk(clk), .rstn(rstn), .satp(satp), .cpu_mode(cpu_mode), .sum(sum),
      .fetch_req_en(fetch_req_en), .fetch_req(fetch_req),
      .fetch_resp_en(fetch_resp_en), .fetch_resp_data(fetch_resp_data),
      .mem_req_en(mem_req_en), .mem_req(mem_req),
      .mem_resp_en(mem_resp_en), .mem_resp_data(mem_resp_data),
      .exc_en(exc_en), .exc_code(exc_code), .exc_tval(exc_tval),
      .req_en(req_en), .req(req), .resp_en(resp_en), .resp_data(resp_data),
      .flush_tlb(flush_tlb)
   );

   mmu_mem_model i_mem (
      .clk(clk), .rstn(rstn), .req_en(req_en), .req(req),
      .resp_en(resp_en), .resp_data(resp_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (!rstn && req_en) begin
         reqs.push_back(req);
      end
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the MMU stopped answering after %0d cycles", cycles);
         $display("TESTS FAILED");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   task automatic report_error(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("TESTS FAILED");
      $fatal(1, "check failed");
   endtask

   task automatic check(input bit cond, input string msg);
      assert (cond) else report_error(msg);
   endtask

   // every response is a single-cycle pulse
   assert property (@(posedge clk) disable iff (rstn) fetch_resp_en |=> !fetch_resp_en)
      else report_error("fetch response longer than one cycle");
   assert property (@(posedge clk) disable iff (rstn) mem_resp_en |=> !mem_resp_en)
      else report_error("data response longer than one cycle");

   // any accepted request clears a pending fault
   assert property (@(posedge clk) disable iff (rstn)
                    $rose(fetch_req_en || mem_req_en) |=> !exc_en)
      else report_error("exc_en not cleared by the next request");

   function automatic logic [31:0] mem_word(input vaddr_t a);
      vaddr_t w;
      w = {a[31:2], 2'b00};
      return pt.exists(w) ? pt[w] : ({w[15:0], w[31:16]} ^ 32'h3c5a_a5c3);
   endfunction

   function automatic mem_req_t make_req(input logic m, input vaddr_t a,
                                         input logic [31:0] d, input logic [3:0] s);
      mem_req_t r;
      r.mode = m;
      r.addr = a;
      r.wdata = d;
      r.wstrb = s;
      return r;
   endfunction

   // sv32 walk over the reference tables
   task automatic ref_walk(input vaddr_t va, output vaddr_t a1, output vaddr_t a0,
                           output vaddr_t pa, output bit mega);
      pte_t p1;
      pte_t p0;
      a1 = (32'(ROOT_PPN) << 12) + (32'(va[31:22]) << 2);
      p1 = pt[a1];
      mega = p1[1] || p1[3];
      a0 = '0;
      if (mega) begin
         pa = {p1[29:20], va[21:0]};
      end else begin
         a0 = (32'(p1[29:10]) << 12) + (32'(va[21:12]) << 2);
         p0 = pt[a0];
         pa = {p0[29:10], va[11:0]};
      end
   endtask

   task automatic put_pte(input vaddr_t a, input pte_t v);
      pt[a] = v;
      i_mem.mem[a] = v;
   endtask

   task automatic wait_pulse(input bit on_fetch);
      bit done;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         check(on_fetch ? !mem_resp_en : !fetch_resp_en, "response on the wrong port");
         if (on_fetch ? fetch_resp_en : mem_resp_en) begin
            done = 1'b1;
            rdata = on_fetch ? fetch_resp_data : mem_resp_data;
            exc_seen = exc_en;
            exc_c = exc_code;
            exc_t = exc_tval;
         end
      end
   endtask

   task automatic transact(input bit on_fetch, input mem_req_t r, input bit flush);
      reqs.delete();
      @(posedge clk);
      if (on_fetch) begin
         fetch_req_en <= 1'b1;
         fetch_req <= r;
      end else begin
         mem_req_en <= 1'b1;
         mem_req <= r;
      end
      flush_tlb <= flush;
      wait_pulse(on_fetch);
      @(posedge clk);
      fetch_req_en <= 1'b0;
      mem_req_en <= 1'b0;
      flush_tlb <= 1'b0;
   endtask

   task automatic check_translated(input vaddr_t va, input bit walked, input bit is_read);
      vaddr_t a1;
      vaddr_t a0;
      vaddr_t pa;
      bit     mega;
      ref_walk(va, a1, a0, pa, mega);
      check(!exc_seen, "unexpected page fault");
      if (!walked) begin
         check(reqs.size() == 1, "TLB hit made more than one memory request");
         check(reqs[0].addr == pa, "wrong translated address on TLB hit");
      end else if (mega) begin
         check(reqs.size() == 2, "megapage walk request count");
         check(reqs[0].addr == a1 && reqs[1].addr == pa, "megapage walk addresses");
      end else begin
         check(reqs.size() == 3, "two-level walk request count");
         check(reqs[0].addr == a1 && reqs[0].mode == MEM_READ, "first PTE read");
         check(reqs[1].addr == a0 && reqs[1].mode == MEM_READ, "second PTE read");
         check(reqs[2].addr == pa, "translated access address");
      end
      if (is_read) begin
         check(rdata == mem_word(pa), "wrong response data");
      end
   endtask

   task automatic check_fault(input exc_code_t code, input vaddr_t va, input int n);
      check(exc_seen, "missing page fault");
      check(exc_c == code, $sformatf("fault code %0d, expected %0d", exc_c, code));
      check(exc_t == va, "wrong fault address");
      check(rdata == '0, "faulting access returned data");
      check(reqs.size() == n, "fault made the wrong number of requests");
   endtask

   initial begin
      cycles = 0;
      rstn = 1'b1;
      satp = '0;
      cpu_mode = PRIV_S;
      sum = 1'b0;
      flush_tlb = 1'b0;
      fetch_req_en = 1'b0;
      fetch_req = '0;
      mem_req_en = 1'b0;
      mem_req = '0;

      // root entries: one table, one aligned megapage, one misaligned
      put_pte(32'h0010_0400, 32'h0004_0401);
      put_pte(32'h0010_0800, 32'h0010_000f);
      put_pte(32'h0010_0840, 32'h0010_040f);
      // level-0 leaves: rwx, r, rw, user rwx
      put_pte(32'h0010_1004, 32'h0008_000f);
      put_pte(32'h0010_1008, 32'h0008_0403);
      put_pte(32'h0010_100c, 32'h0008_0807);
      put_pte(32'h0010_1010, 32'h0008_0c1f);

      repeat (10) @(posedge clk);
      rstn <= 1'b0;

      ////////////////////////////////////////////////////////////////////////
      // bypass
      ////////////////////////////////////////////////////////////////////////
      transact(1'b1, make_req(MEM_READ, 32'h0000_3008, '0, '0), 1'b0);
      check(reqs.size() == 1 && reqs[0].addr == 32'h0000_3008, "bypass fetch address");
      check(rdata == mem_word(32'h0000_3008) && !exc_seen, "bypass fetch data");
      transact(1'b0, make_req(MEM_WRITE, 32'h0000_2004, 32'hdead_beef, 4'ha), 1'b0);
      check(reqs.size() == 1, "bypass store request count");
      check(reqs[0] == make_req(MEM_WRITE, 32'h0000_2004, 32'hdead_beef, 4'ha),
            "bypass store changed the request");
      @(posedge clk);
      satp <= SATP_ON;
      cpu_mode <= PRIV_M;
      transact(1'b0, make_req(MEM_READ, 32'h4000_1234, '0, '0), 1'b0);
      check(reqs.size() == 1 && reqs[0].addr == 32'h4000_1234, "machine mode translated");
      check(rdata == mem_word(32'h4000_1234) && !exc_seen, "machine mode data");

      ////////////////////////////////////////////////////////////////////////
      // walk, tlb hit, flush
      ////////////////////////////////////////////////////////////////////////
      @(posedge clk);
      cpu_mode <= PRIV_S;
      transact(1'b0, make_req(MEM_READ, 32'h4000_1234, '0, '0), 1'b0);
      check_translated(32'h4000_1234, 1'b1, 1'b1);
      transact(1'b1, make_req(MEM_READ, 32'h4000_1238, '0, '0), 1'b0);
      check_translated(32'h4000_1238, 1'b0, 1'b1);
      transact(1'b0, make_req(MEM_READ, 32'h4000_1234, '0, '0), 1'b1);
      check(reqs.size() == 0 && rdata == '0, "flush on data port");
      transact(1'b1, make_req(MEM_READ, 32'h4000_1234, '0, '0), 1'b1);
      check(reqs.size() == 0 && rdata == '0, "flush on fetch port");
      transact(1'b0, make_req(MEM_READ, 32'h4000_1234, '0, '0), 1'b0);
      check_translated(32'h4000_1234, 1'b1, 1'b1);

      ////////////////////////////////////////////////////////////////////////
      // megapages and faults
      ////////////////////////////////////////////////////////////////////////
      transact(1'b0, make_req(MEM_READ, 32'h8012_3456, '0, '0), 1'b0);
      check_translated(32'h8012_3456, 1'b1, 1'b1);
      transact(1'b0, make_req(MEM_READ, 32'h8412_3456, '0, '0), 1'b0);
      check_fault(EXC_LOAD_PF, 32'h8412_3456, 1);
      @(negedge clk);
      check(exc_en, "exc_en dropped without a new request");
      transact(1'b0, make_req(MEM_WRITE, 32'h4000_2010, 32'h1234_5678, 4'hf), 1'b0);
      check_fault(EXC_STORE_PF, 32'h4000_2010, 2);
      transact(1'b1, make_req(MEM_READ, 32'h4000_3000, '0, '0), 1'b0);
      check_fault(EXC_FETCH_PF, 32'h4000_3000, 2);
      transact(1'b0, make_req(MEM_READ, 32'h4000_4000, '0, '0), 1'b0);
      check_fault(EXC_LOAD_PF, 32'h4000_4000, 2);
      @(posedge clk);
      sum <= 1'b1;
      transact(1'b0, make_req(MEM_READ, 32'h4000_4000, '0, '0), 1'b0);
      check_translated(32'h4000_4000, 1'b1, 1'b1);

      ////////////////////////////////////////////////////////////////////////
      // fetch wins over data
      ////////////////////////////////////////////////////////////////////////
      reqs.delete();
      @(posedge clk);
      fetch_req_en <= 1'b1;
      fetch_req <= make_req(MEM_READ, 32'h4000_1240, '0, '0);
      mem_req_en <= 1'b1;
      mem_req <= make_req(MEM_READ, 32'h4000_4004, '0, '0);
      wait_pulse(1'b1);
      check_translated(32'h4000_1240, 1'b0, 1'b1);
      reqs.delete();
      @(posedge clk);
      fetch_req_en <= 1'b0;
      wait_pulse(1'b0);
      check_translated(32'h4000_4004, 1'b0, 1'b1);
      @(posedge clk);
      mem_req_en <= 1'b0;

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// ==== rtl/mmu_pkg.sv ====
package mmu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////

   localparam int XLEN  = 32;
   localparam int VPN_W = 20;
   localparam int PPN_W = 22;
   localparam int EXC_W = 5;

   // satp mode bit, 1 selects sv32
   localparam int SATP_MODE = 31;

   // pte flag positions
   localparam int PTE_V = 0;
   localparam int PTE_R = 1;
   localparam int PTE_W = 2;
   localparam int PTE_X = 3;
   localparam int PTE_U = 4;

   // memory request mode
   localparam logic MEM_READ  = 1'b0;
   localparam logic MEM_WRITE = 1'b1;

   typedef logic [XLEN-1:0]  vaddr_t;
   typedef logic [XLEN-1:0]  pte_t;
   typedef logic [VPN_W-1:0] vpn_t;
   typedef logic [PPN_W-1:0] ppn_t;
   typedef logic [XLEN-1:0]  satp_t;
   typedef logic [EXC_W-1:0] exc_code_t;

   typedef enum logic [1:0] {
      PRIV_U = 2'd0,
      PRIV_S = 2'd1,
      PRIV_M = 2'd3
   } priv_t;

   typedef enum logic [1:0] {
      ACC_FETCH,
      ACC_LOAD,
      ACC_STORE
   } access_t;

   typedef enum logic [2:0] {
      S_IDLE,
      S_PTE1,
      S_PTE0,
      S_ACCESS,
      S_RESPOND
   } walk_state_t;

   typedef struct packed {
      logic                mode;
      vaddr_t              addr;
      logic [XLEN-1:0]     wdata;
      logic [XLEN/8-1:0]   wstrb;
   } mem_req_t;

   typedef struct packed {
      logic valid;
      vpn_t tag;
      ppn_t ppn;
   } tlb_entry_t;

   // page fault causes
   localparam exc_code_t EXC_FETCH_PF = 5'd12;
   localparam exc_code_t EXC_LOAD_PF  = 5'd13;
   localparam exc_code_t EXC_STORE_PF = 5'd15;

endpackage

// ==== rtl/mmu_pte_check.sv ====
module mmu_pte_check import mmu_pkg::*; (
   input  pte_t    pte,
   input  logic    level,
   input  access_t access,
   input  priv_t   cpu_mode,
   input  logic    sum,
   input  vaddr_t  vaddr,

   output logic    fault,
   output logic    next_level,
   output ppn_t    leaf_ppn,
   output vaddr_t  next_addr
);

   ppn_t pte_ppn;
   vpn_t vpn;
   logic invalid;
   logic is_leaf;
   logic user_ok;
   logic perm_ok;
   logic misaligned;

   assign pte_ppn = pte[31:10];
   assign vpn = vaddr[31:12];

   // w without r is reserved
   assign invalid = !pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]);
   assign is_leaf = pte[PTE_R] || pte[PTE_X];

   always_comb begin
      if (pte[PTE_U]) begin
         user_ok = !(cpu_mode == PRIV_S && !sum);
      end else begin
         user_ok = (cpu_mode != PRIV_U);
      end
   end

   always_comb begin
      case (access)
         ACC_FETCH: perm_ok = pte[PTE_X];
         ACC_LOAD:  perm_ok = pte[PTE_R];
         ACC_STORE: perm_ok = pte[PTE_W];
         default:   perm_ok = 1'b0;
      endcase
   end

   // megapage must be 4 MiB aligned
   assign misaligned = level && (pte_ppn[9:0] != '0);

   assign fault = invalid || (is_leaf ? (!user_ok || !perm_ok || misaligned) : !level);
   assign next_level = !invalid && !is_leaf && level;

   // level-0 entry address, top two ppn bits dropped
   assign next_addr = {pte_ppn[19:0], vpn[9:0], 2'b00};

   assign leaf_ppn = level ? {pte_ppn[21:10], vpn[9:0]} : pte_ppn;

endmodule

// ==== rtl/mmu_tlb.sv ====
module mmu_tlb import mmu_pkg::*; #(
   parameter int TLB_ENTRIES = 16
) (
   input  logic clk,
   input  logic rstn,

   input  vpn_t lookup_vpn,
   output logic hit,
   output ppn_t hit_ppn,

   input  logic fill_en,
   input  vpn_t fill_vpn,
   input  ppn_t fill_ppn,

   input  logic flush_en
);

   localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

   tlb_entry_t entries [TLB_ENTRIES];

   logic             fill_present;
   logic [IDX_W-1:0] fill_idx;

   ////////////////////////////////////////////////////////////////////////////
   // lookup
   ////////////////////////////////////////////////////////////////////////////

   // scan downwards so the lowest matching index wins
   always_comb begin
      hit = 1'b0;
      hit_ppn = '0;
      for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
         if (entries[i].valid && entries[i].tag == lookup_vpn) begin
            hit = 1'b1;
            hit_ppn = entries[i].ppn;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // fill slot
   ////////////////////////////////////////////////////////////////////////////

   // lowest free entry; stays 0 when the table is full
   always_comb begin
      fill_present = 1'b0;
      fill_idx = '0;
      for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
         if (entries[i].valid && entries[i].tag == fill_vpn) begin
            fill_present = 1'b1;
         end
         if (!entries[i].valid) begin
            fill_idx = IDX_W'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rstn || flush_en) begin
         for (int i = 0; i < TLB_ENTRIES; i++) begin
            entries[i].valid <= 1'b0;
         end
      end else if (fill_en && !fill_present) begin
         entries[fill_idx].valid <= 1'b1;
         entries[fill_idx].tag <= fill_vpn;
         entries[fill_idx].ppn <= fill_ppn;
      end
   end

endmodule

// ==== rtl/mmu_top.sv ====
module mmu_top import mmu_pkg::*; #(
   parameter int TLB_ENTRIES = 16
) (
   input  logic        clk,
   input  logic        rstn,

   input  satp_t       satp,
   input  priv_t       cpu_mode,
   input  logic        sum,

   input  logic        fetch_req_en,
   input  mem_req_t    fetch_req,
   output logic        fetch_resp_en,
   output logic [31:0] fetch_resp_data,

   input  logic        mem_req_en,
   input  mem_req_t    mem_req,
   output logic        mem_resp_en,
   output logic [31:0] mem_resp_data,

   output logic        exc_en,
   output exc_code_t   exc_code,
   output vaddr_t      exc_tval,

   output logic        req_en,
   output mem_req_t    req,
   input  logic        resp_en,
   input  logic [31:0] resp_data,

   input  logic        flush_tlb
);

   vpn_t    lookup_vpn;
   logic    hit;
   ppn_t    hit_ppn;
   logic    fill_en;
   vpn_t    fill_vpn;
   ppn_t    fill_ppn;
   logic    flush_en;

   pte_t    pte;
   logic    level;
   access_t access;
   vaddr_t  vaddr;
   logic    fault;
   logic    next_level;
   ppn_t    leaf_ppn;
   vaddr_t  next_addr;

   mmu_tlb #(
      .TLB_ENTRIES(TLB_ENTRIES)
   ) i_tlb (
      .clk(clk),
      .rstn(rstn),
      .lookup_vpn(lookup_vpn),
      .hit(hit),
      .hit_ppn(hit_ppn),
      .fill_en(fill_en),
      .fill_vpn(fill_vpn),
      .fill_ppn(fill_ppn),
      .flush_en(flush_en)
   );

   mmu_pte_check i_pte_check (
      .pte(pte),
      .level(level),
      .access(access),
      .cpu_mode(cpu_mode),
      .sum(sum),
      .vaddr(vaddr),
      .fault(fault),
      .next_level(next_level),
      .leaf_ppn(leaf_ppn),
      .next_addr(next_addr)
   );

   mmu_walker i_walker (
      .clk(clk),
      .rstn(rstn),
      .satp(satp),
      .cpu_mode(cpu_mode),
      .sum(sum),
      .flush_tlb(flush_tlb),
      .fetch_req_en(fetch_req_en),
      .fetch_req(fetch_req),
      .fetch_resp_en(fetch_resp_en),
      .fetch_resp_data(fetch_resp_data),
      .mem_req_en(mem_req_en),
      .mem_req(mem_req),
      .mem_resp_en(mem_resp_en),
      .mem_resp_data(mem_resp_data),
      .exc_en(exc_en),
      .exc_code(exc_code),
      .exc_tval(exc_tval),
      .req_en(req_en),
      .req(req),
      .resp_en(resp_en),
      .resp_data(resp_data),
      .lookup_vpn(lookup_vpn),
      .hit(hit),
      .hit_ppn(hit_ppn),
      .fill_en(fill_en),
      .fill_vpn(fill_vpn),
      .fill_ppn(fill_ppn),
      .flush_en(flush_en),
      .pte(pte),
      .level(level),
      .access(access),
      .vaddr(vaddr),
      .fault(fault),
      .next_level(next_level),
      .leaf_ppn(leaf_ppn),
      .next_addr(next_addr)
   );

endmodule

// ==== rtl/mmu_walker.sv ====
module mmu_walker import mmu_pkg::*; (
   input  logic        clk,
   input  logic        rstn,

   input  satp_t       satp,
   input  priv_t       cpu_mode,
   input  logic        sum,
   input  logic        flush_tlb,

   input  logic        fetch_req_en,
   input  mem_req_t    fetch_req,
   output logic        fetch_resp_en,
   output logic [31:0] fetch_resp_data,

   input  logic        mem_req_en,
   input  mem_req_t    mem_req,
   output logic        mem_resp_en,
   output logic [31:0] mem_resp_data,

   output logic        exc_en,
   output exc_code_t   exc_code,
   output vaddr_t      exc_tval,

   output logic        req_en,
   output mem_req_t    req,
   input  logic        resp_en,
   input  logic [31:0] resp_data,

   output vpn_t        lookup_vpn,
   input  logic        hit,
   input  ppn_t        hit_ppn,
   output logic        fill_en,
   output vpn_t        fill_vpn,
   output ppn_t        fill_ppn,
   output logic        flush_en,

   output pte_t        pte,
   output logic        level,
   output access_t     access,
   output vaddr_t      vaddr,
   input  logic        fault,
   input  logic        next_level,
   input  ppn_t        leaf_ppn,
   input  vaddr_t      next_addr
);

   walk_state_t state;
   mem_req_t    cur;
   access_t     acc_q;
   logic        from_fetch;
   logic [2:0]  ctx_q;

   mem_req_t    sel_req;
   access_t     sel_acc;
   logic        accept;
   logic        translate;
   logic        tlb_ok;
   logic        pte_state;
   logic        walk_fault;
   logic        issue;
   mem_req_t    issue_req;
   logic        resp_fire;
   logic        resp_to_fetch;
   logic [31:0] resp_word;
   exc_code_t   fault_code;

   ////////////////////////////////////////////////////////////////////////////
   // request selection, fetch first
   ////////////////////////////////////////////////////////////////////////////

   assign sel_req = fetch_req_en ? fetch_req : mem_req;

   always_comb begin
      if (fetch_req_en) begin
         sel_acc = ACC_FETCH;
      end else if (mem_req.mode == MEM_WRITE) begin
         sel_acc = ACC_STORE;
      end else begin
         sel_acc = ACC_LOAD;
      end
   end

   assign accept = (state == S_IDLE) && (fetch_req_en || mem_req_en);
   assign translate = satp[SATP_MODE] && (cpu_mode != PRIV_M);

   // entries hold no permission bits, so a new mode or sum forces a walk
   assign tlb_ok = hit && (ctx_q == {cpu_mode, sum});

   assign lookup_vpn = sel_req.addr[31:12];
   assign flush_en = accept && flush_tlb;

   ////////////////////////////////////////////////////////////////////////////
   // checker and tlb fill
   ////////////////////////////////////////////////////////////////////////////

   assign pte = resp_data;
   assign level = (state == S_PTE1);
   assign access = acc_q;
   assign vaddr = cur.addr;

   assign pte_state = (state == S_PTE1) || (state == S_PTE0);
   assign walk_fault = pte_state && resp_en && fault;

   assign fill_en = pte_state && resp_en && !fault && !next_level;
   assign fill_vpn = cur.addr[31:12];
   assign fill_ppn = leaf_ppn;

   always_comb begin
      case (acc_q)
         ACC_FETCH: fault_code = EXC_FETCH_PF;
         ACC_STORE: fault_code = EXC_STORE_PF;
         default:   fault_code = EXC_LOAD_PF;
      endcase
   end

   // next memory request
   always_comb begin
      issue = 1'b0;
      issue_req = sel_req;
      if (accept && !flush_tlb) begin
         issue = 1'b1;
         if (translate && tlb_ok) begin
            issue_req.addr = {hit_ppn[19:0], sel_req.addr[11:0]};
         end else if (translate) begin
            issue_req = '{mode: MEM_READ,
                          addr: {satp[19:0], sel_req.addr[31:22], 2'b00},
                          wdata: '0,
                          wstrb: '0};
         end
      end else if (pte_state && resp_en && !fault) begin
         issue = 1'b1;
         if (next_level) begin
            issue_req = '{mode: MEM_READ, addr: next_addr, wdata: '0, wstrb: '0};
         end else begin
            issue_req = cur;
            issue_req.addr = {leaf_ppn[19:0], cur.addr[11:0]};
         end
      end
   end

   // response to the requester, zero data on flush or fault
   assign resp_fire = flush_en || walk_fault || (state == S_ACCESS && resp_en);
   assign resp_to_fetch = (state == S_IDLE) ? fetch_req_en : from_fetch;
   assign resp_word = (state == S_ACCESS) ? resp_data : '0;

   ////////////////////////////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         state <= S_IDLE;
         req_en <= 1'b0;
         fetch_resp_en <= 1'b0;
         mem_resp_en <= 1'b0;
         exc_en <= 1'b0;
         ctx_q <= '0;
      end else begin
         req_en <= issue;
         fetch_resp_en <= resp_fire && resp_to_fetch;
         mem_resp_en <= resp_fire && !resp_to_fetch;
         if (accept) begin
            exc_en <= 1'b0;
         end else if (walk_fault) begin
            exc_en <= 1'b1;
         end
         if (accept && translate && !flush_tlb) begin
            ctx_q <= {cpu_mode, sum};
         end
         case (state)
            S_IDLE: begin
               if (accept) begin
                  if (flush_tlb) begin
                     state <= S_RESPOND;
                  end else if (!translate || tlb_ok) begin
                     state <= S_ACCESS;
                  end else begin
                     state <= S_PTE1;
                  end
               end
            end
            S_PTE1, S_PTE0: begin
               if (resp_en) begin
                  if (fault) begin
                     state <= S_RESPOND;
                  end else if (next_level) begin
                     state <= S_PTE0;
                  end else begin
                     state <= S_ACCESS;
                  end
               end
            end
            S_ACCESS: begin
               if (resp_en) begin
                  state <= S_RESPOND;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         req <= issue_req;
      end
      if (accept) begin
         cur <= sel_req;
         acc_q <= sel_acc;
         from_fetch <= fetch_req_en;
      end
      if (walk_fault) begin
         exc_code <= fault_code;
         exc_tval <= cur.addr;
      end
      if (resp_fire && resp_to_fetch) begin
         fetch_resp_data <= resp_word;
      end
      if (resp_fire && !resp_to_fetch) begin
         mem_resp_data <= resp_word;
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; status follows the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmu \
   -f sources.f -o tb_mmu &&
./obj_dir/tb_mmu | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sources.f ====
rtl/mmu_pkg.sv
rtl/mmu_tlb.sv
rtl/mmu_pte_check.sv
rtl/mmu_walker.sv
rtl/mmu_top.sv
bench/mmu_mem_model.sv
bench/tb_mmu.sv
